// ==== logic/byte_pattern_match.sv ====
`timescale 1ns/1ns

module byte_pattern_match import io_trig_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic [7:0]  byte_data,
	input  logic        byte_valid,
	input  logic [63:0] match_data,
	input  logic [7:0]  byte_mask,   // Bit i enables compare of byte i
	output logic        trig_out
);

	logic [63:0] history;                        // Byte 0 newest
	logic [7:0]  byte_hit;                       // Combinational per-byte compare
	logic [7:0]  byte_match;                     // Registered compare
	logic [1:0]  filt;                           // Glitch filter stages
	logic        trig_int;
	logic [$clog2(STRETCH_LEN)-1:0] stretch_cnt; // Wraps back to zero

	// Shift register of decoded bytes
	always_ff @(posedge clk) begin
		if (reset)
			history <= 64'd0;
		else if (byte_valid)
			history <= {history[55:0], byte_data};
	end

	// Equal or masked out counts as a hit
	always_comb begin
		for (int i = 0; i < 8; i++)
			byte_hit[i] = (history[i*8 +: 8] == match_data[i*8 +: 8]) | ~byte_mask[i];
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			byte_match <= 8'd0;
			filt <= 2'b00;
		end else begin
			byte_match <= byte_hit;
			filt[0] <= &byte_match;
			filt[1] <= filt[0];
		end
	end

	// Full match on two cycles in a row
	assign trig_int = &filt;

	// Stretch so slow ADC clocks see the pulse
	always_ff @(posedge clk) begin
		if (reset) begin
			stretch_cnt <= '0;
			trig_out <= 1'b0;
		end else if (trig_int) begin
			stretch_cnt <= 1; // Restart while match holds
			trig_out <= 1'b1;
		end else if (stretch_cnt != 0) begin
			stretch_cnt <= stretch_cnt + 1'b1;
			trig_out <= 1'b1;
		end else
			trig_out <= 1'b0;
	end

endmodule

// ==== logic/io_decode_trig.sv ====
`timescale 1ns/1ns

module io_decode_trig import io_trig_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic [5:0]  reg_address,
	input  logic [15:0] reg_bytecnt,
	input  logic [7:0]  reg_datai,
	output logic [7:0]  reg_datao,
	input  logic        reg_read,
	input  logic        reg_write,
	input  logic [5:0]  reg_hypaddress,
	output logic [15:0] reg_hyplen,
	input  logic        sck,
	input  logic        mosi,
	input  logic        miso,
	input  logic        pdid_cs,     // SPI chip select
	output logic        trig_out
);

	src_sel_t    cfg_src;
	match_mod_t  cfg_mod;
	logic [7:0]  byte_mask;
	logic [15:0] baud_div;
	logic [63:0] match_data;
	logic        data_line;     // Selected serial input
	logic        spi_en, uart_en;
	logic [7:0]  spi_data, uart_data, byte_data;
	logic        spi_valid, uart_valid, byte_valid;

	io_trig_regs u_regs (
		.clk, .reset, .reg_address, .reg_bytecnt, .reg_datai, .reg_datao,
		.reg_read, .reg_write, .reg_hypaddress, .reg_hyplen,
		.cfg_src, .cfg_mod, .byte_mask, .baud_div, .match_data
	);

	// Source line, unused codes look like an idle line
	always_comb begin
		case (cfg_src)
			SRC_MOSI: data_line = mosi;
			SRC_MISO: data_line = miso;
			default:  data_line = 1'b1; // SRC_EXT and SRC_PDID not wired
		endcase
	end

	// One decoder at a time
	always_comb begin
		spi_en = 1'b0;
		uart_en = 1'b0;
		case (cfg_mod)
			MOD_SPI:   spi_en = 1'b1;
			MOD_USART: uart_en = 1'b1;
			default: ; // MOD_NONE
		endcase
	end

	spi_byte_rx u_spi (
		.clk, .reset, .sck, .cs(pdid_cs), .sdata(data_line), .enable(spi_en),
		.byte_data(spi_data), .byte_valid(spi_valid)
	);

	uart_byte_rx u_uart (
		.clk, .reset, .rxd(data_line), .enable(uart_en), .baud_div,
		.byte_data(uart_data), .byte_valid(uart_valid)
	);

	assign byte_valid = spi_valid | uart_valid; // Only enabled decoder pulses
	assign byte_data = spi_en ? spi_data : uart_data;

	byte_pattern_match u_match (
		.clk, .reset, .byte_data, .byte_valid, .match_data, .byte_mask, .trig_out
	);

endmodule

// ==== logic/io_trig_pkg.sv ====
package io_trig_pkg;

	// Register bus addresses
	localparam logic [5:0] CFG_ADDR  = 6'd57; // Trigger configuration
	localparam logic [5:0] DATA_ADDR = 6'd58; // Pattern to match

	localparam int REG_BYTES = 8; // Length of both registers, also the hyper length

	// Trigger held this many cycles after the internal match drops
	localparam int STRETCH_LEN = 128;

	// Configuration register layout
	localparam int CFG_SRC_LSB      = 5; // Byte 0 bits 7..5
	localparam int CFG_MOD_LSB      = 0; // Byte 0 bits 3..0
	localparam int CFG_MASK_BYTE    = 2; // Byte bitmap, LSB is newest byte
	localparam int CFG_BAUD_HI_BYTE = 3;
	localparam int CFG_BAUD_LO_BYTE = 4;

	// Data line feeding the decoders
	typedef enum logic [2:0] {
		SRC_EXT  = 3'd0, // Trigger mux source, not wired here
		SRC_MOSI = 3'd1,
		SRC_MISO = 3'd2,
		SRC_PDID = 3'd3  // Not wired here
	} src_sel_t;

	// Decoder choice
	typedef enum logic [3:0] {
		MOD_NONE  = 4'd0,
		MOD_USART = 4'd1,
		MOD_SPI   = 4'd2
	} match_mod_t;

endpackage

// ==== logic/io_trig_regs.sv ====
`timescale 1ns/1ns

module io_trig_regs import io_trig_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic [5:0]  reg_address,
	input  logic [15:0] reg_bytecnt,  // Byte index in low three bits
	input  logic [7:0]  reg_datai,
	output logic [7:0]  reg_datao,
	input  logic        reg_read,
	input  logic        reg_write,
	input  logic [5:0]  reg_hypaddress,
	output logic [15:0] reg_hyplen,
	output src_sel_t    cfg_src,
	output match_mod_t  cfg_mod,
	output logic [7:0]  byte_mask,
	output logic [15:0] baud_div,
	output logic [63:0] match_data
);

	logic [REG_BYTES*8-1:0] cfg_reg;  // Configuration bytes 0..7
	logic [REG_BYTES*8-1:0] data_reg; // Match bytes, byte 0 vs newest
	logic [5:0] bit_base;             // Bit offset of the addressed byte

	assign bit_base = {reg_bytecnt[2:0], 3'b000};

	// Byte-wise writes
	always_ff @(posedge clk) begin
		if (reset) begin
			cfg_reg <= '0;
			data_reg <= '0;
		end else if (reg_write) begin
			case (reg_address)
				CFG_ADDR:  cfg_reg[bit_base +: 8] <= reg_datai;
				DATA_ADDR: data_reg[bit_base +: 8] <= reg_datai;
				default: ; // Other blocks own the rest of the map
			endcase
		end
	end

	// Read data held until next strobe
	always_ff @(posedge clk) begin
		if (reset)
			reg_datao <= 8'd0;
		else if (reg_read) begin
			case (reg_address)
				CFG_ADDR:  reg_datao <= cfg_reg[bit_base +: 8];
				DATA_ADDR: reg_datao <= data_reg[bit_base +: 8];
				default:   reg_datao <= 8'd0;
			endcase
		end
	end

	// Hyper length lookup, purely combinational
	always_comb begin
		if (reg_hypaddress == CFG_ADDR || reg_hypaddress == DATA_ADDR)
			reg_hyplen = 16'(REG_BYTES);
		else
			reg_hyplen = 16'd0;
	end

	// Field split
	assign cfg_src = src_sel_t'(cfg_reg[CFG_SRC_LSB +: $bits(src_sel_t)]);
	assign cfg_mod = match_mod_t'(cfg_reg[CFG_MOD_LSB +: $bits(match_mod_t)]);
	assign byte_mask = cfg_reg[CFG_MASK_BYTE*8 +: 8];
	assign baud_div = {cfg_reg[CFG_BAUD_HI_BYTE*8 +: 8], cfg_reg[CFG_BAUD_LO_BYTE*8 +: 8]};
	assign match_data = data_reg;

endmodule

// ==== logic/spi_byte_rx.sv ====
`timescale 1ns/1ns

module spi_byte_rx (
	input  logic       clk,
	input  logic       reset,
	input  logic       sck,
	input  logic       cs,          // Active low select
	input  logic       sdata,
	input  logic       enable,
	output logic [7:0] byte_data,
	output logic       byte_valid
);

	logic [1:0] sck_sync, cs_sync, sdata_sync; // Two-flop synchronizers
	logic       sck_prev;                      // For edge detect
	logic       sck_rise;
	logic [2:0] bit_cnt;
	logic [6:0] shift;                         // First seven bits of the byte

	always_ff @(posedge clk) begin
		if (reset) begin
			sck_sync <= 2'b00;
			cs_sync <= 2'b11; // Deselected
			sdata_sync <= 2'b00;
			sck_prev <= 1'b0;
		end else begin
			sck_sync <= {sck_sync[0], sck};
			cs_sync <= {cs_sync[0], cs};
			sdata_sync <= {sdata_sync[0], sdata};
			sck_prev <= sck_sync[1];
		end
	end

	assign sck_rise = sck_sync[1] & ~sck_prev;

	always_ff @(posedge clk) begin
		byte_valid <= 1'b0; // One cycle pulse
		if (reset)
			bit_cnt <= 3'd0;
		else if (cs_sync[1] || !enable)
			bit_cnt <= 3'd0; // Frame aborted
		else if (sck_rise) begin
			bit_cnt <= bit_cnt + 3'd1;
			shift <= {shift[5:0], sdata_sync[1]}; // MSB first
			if (bit_cnt == 3'd7) begin
				byte_data <= {shift, sdata_sync[1]};
				byte_valid <= 1'b1;
			end
		end
	end

endmodule

// ==== logic/uart_byte_rx.sv ====
`timescale 1ns/1ns

module uart_byte_rx (
	input  logic        clk,
	input  logic        reset,
	input  logic        rxd,
	input  logic        enable,
	input  logic [15:0] baud_div,   // Clocks per bit
	output logic [7:0]  byte_data,
	output logic        byte_valid
);

	typedef enum logic [1:0] {
		ST_IDLE,
		ST_START,
		ST_DATA,
		ST_STOP
	} uart_state_t;

	uart_state_t state;
	logic [1:0]  rxd_sync;
	logic        rxd_prev;
	logic [15:0] baud_cnt;  // Counts down to the next sample point
	logic [2:0]  bit_cnt;
	logic [7:0]  shift;     // LSB first

	always_ff @(posedge clk) begin
		if (reset) begin
			rxd_sync <= 2'b11; // Line idles high
			rxd_prev <= 1'b1;
		end else begin
			rxd_sync <= {rxd_sync[0], rxd};
			rxd_prev <= rxd_sync[1];
		end
	end

	always_ff @(posedge clk) begin
		byte_valid <= 1'b0;
		if (reset) begin
			state <= ST_IDLE;
			baud_cnt <= 16'd0;
			bit_cnt <= 3'd0;
		end else if (!enable)
			state <= ST_IDLE;
		else begin
			case (state)
				ST_IDLE: if (rxd_prev && !rxd_sync[1]) begin
					state <= ST_START;
					baud_cnt <= baud_div >> 1; // Aim at middle of start bit
				end
				ST_START: if (baud_cnt != 16'd0)
					baud_cnt <= baud_cnt - 16'd1;
				else if (!rxd_sync[1]) begin
					state <= ST_DATA;
					baud_cnt <= baud_div - 16'd1;
					bit_cnt <= 3'd0;
				end else
					state <= ST_IDLE; // Glitch, not a start bit
				ST_DATA: if (baud_cnt != 16'd0)
					baud_cnt <= baud_cnt - 16'd1;
				else begin
					shift <= {rxd_sync[1], shift[7:1]};
					bit_cnt <= bit_cnt + 3'd1;
					baud_cnt <= baud_div - 16'd1;
					if (bit_cnt == 3'd7)
						state <= ST_STOP;
				end
				ST_STOP: if (baud_cnt != 16'd0)
					baud_cnt <= baud_cnt - 16'd1;
				else begin
					state <= ST_IDLE;
					byte_data <= shift;
					byte_valid <= rxd_sync[1]; // Framing error drops the byte
				end
				default: state <= ST_IDLE;
			endcase
		end
	end

endmodule

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the testbench with Verilator and run it from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f vlog.f --top-module tb_io_decode_trig -Mdir obj_dir -o sim
build_status=$?
if [ $build_status -ne 0 ]; then
	echo "Verilator build failed with status $build_status"
	exit $build_status
fi

./obj_dir/sim
sim_status=$?
if [ $sim_status -ne 0 ]; then
	echo "Simulation ended with status $sim_status"
	exit $sim_status
fi

echo "Simulation ended with status 0"
exit 0

// ==== test/io_trig_patterns.txt ====
# op arg1 arg2, hex: W/R addr value | H addr length | S/U byte line (0 mosi, 1 miso)
# C cycles 0 | T level limit (cycles to wait for trig_out)
W 3a 8877665544332211
W 39 c33ca51000ff5a22
R 3a 8877665544332211
R 39 c33ca51000ff5a22
R 3b 0
H 39 8
H 3a 8
H 3b 0
C 96 0
T 0 0
S 88 0
S 77 0
S 66 0
S 55 0
S 44 0
S 33 0
S 22 0
T 0 0
S 11 0
T 1 a
S 99 0
C 78 0
T 1 0
T 0 14
W 39 c33ca51000035a22
S 22 0
S 11 0
T 1 a
S 22 0
C 96 0
T 0 0
S 77 0
C a 0
T 0 0
W 39 c33ca51000035a41
U 22 1
U 11 0
C a 0
T 0 0
U 11 1
T 1 a

// ==== include/tb_io_trig_tasks.svh ====
`ifndef TB_IO_TRIG_TASKS_SVH
`define TB_IO_TRIG_TASKS_SVH

// Stop the run with a reason
task automatic fail_run(input string msg);
	$display("%s", msg);
	$display(">>> FAIL");
	$fatal(1, "Simulation stopped on error");
endtask

task automatic check_value(input string name, input logic [15:0] exp, input logic [15:0] got);
	if (got !== exp)
		fail_run($sformatf("[ERROR] %s exp=%h got=%h", name, exp, got));
endtask

// Whole register, byte 0 first
task automatic bus_write(input logic [5:0] addr, input logic [63:0] value);
	for (int i = 0; i < REG_BYTES; i++) begin
		reg_address = addr;
		reg_bytecnt = 16'(i);
		reg_datai = value[i*8 +: 8];
		reg_write = 1'b1;
		@(negedge clk); // Byte lands on the rising edge in between
	end
	reg_write = 1'b0;
endtask

task automatic bus_read(input logic [5:0] addr, input logic [63:0] value);
	for (int i = 0; i < REG_BYTES; i++) begin
		reg_address = addr;
		reg_bytecnt = 16'(i);
		reg_read = 1'b1;
		@(negedge clk); // reg_datao registered one edge after the strobe
		reg_read = 1'b0;
		check_value($sformatf("reg_datao[byte %0d]", i), {8'd0, value[i*8 +: 8]},
			{8'd0, reg_datao});
	end
endtask

// Mode 0 style, MSB first, four clk per sck period
task automatic send_spi_byte(input logic [7:0] data, input logic on_miso);
	repeat (2 + $urandom % 8) @(negedge clk); // Random gap
	pdid_cs = 1'b0;
	for (int i = 7; i >= 0; i--) begin
		if (on_miso) miso = data[i];
		else mosi = data[i];
		repeat (2) @(negedge clk);
		sck = 1'b1;
		repeat (2) @(negedge clk);
		sck = 1'b0;
	end
	repeat (2) @(negedge clk); // Let the last edge through the synchronizers
	pdid_cs = 1'b1;
	mosi = 1'b1;
	miso = 1'b1;
endtask

// 8N1 frame, LSB first
task automatic send_uart_byte(input logic [7:0] data, input logic on_miso);
	logic [9:0] frame;
	frame = {1'b1, data, 1'b0};
	repeat (2 + $urandom % 8) @(negedge clk);
	for (int i = 0; i < 10; i++) begin
		if (on_miso) miso = frame[i];
		else mosi = frame[i];
		repeat (UART_DIV) @(negedge clk);
	end
endtask

// Level must show up within limit cycles
task automatic wait_trig(input logic level, input int limit);
	int n;
	n = 0;
	while (trig_out !== level && n < limit) begin
		@(negedge clk);
		n++;
	end
	check_value("trig_out", {15'd0, level}, {15'd0, trig_out});
endtask

`endif

// ==== test/tb_io_decode_trig.sv ====
`timescale 1ns/1ns

module tb_io_decode_trig import io_trig_pkg::*; ();

	localparam int SEED = 50710;
	localparam int UART_DIV = 16; // Divider written by the pattern file

	typedef enum logic [2:0] {
		OP_WRITE,  // W addr value
		OP_READ,   // R addr value
		OP_HYPLEN, // H addr length
		OP_SPI,    // S byte line
		OP_UART,   // U byte line
		OP_WAIT,   // C cycles
		OP_TRIG    // T level limit
	} op_t;

	logic        clk = 1'b0;
	logic        reset;
	logic [5:0]  reg_address;
	logic [15:0] reg_bytecnt;
	logic [7:0]  reg_datai;
	logic [7:0]  reg_datao;
	logic        reg_read, reg_write;
	logic [5:0]  reg_hypaddress;
	logic [15:0] reg_hyplen;
	logic        sck, mosi, miso, pdid_cs;
	logic        trig_out;

	op_t         op_q[$];               // Parsed pattern lines
	logic [63:0] arg1_q[$], arg2_q[$];
	int          watchdog_cycles = 0;   // Zero until the file is parsed

	io_decode_trig io_decode_trig_inst (
		.clk, .reset, .reg_address, .reg_bytecnt, .reg_datai, .reg_datao,
		.reg_read, .reg_write, .reg_hypaddress, .reg_hyplen,
		.sck, .mosi, .miso, .pdid_cs, .trig_out
	);

	`include "tb_io_trig_tasks.svh"

	always #20 clk = ~clk; // 40 ns period

	initial begin
		int fd, n;
		string line, op_s;
		logic [63:0] arg1, arg2;
		op_t op;
		reset = 1'b1;
		reg_address = 6'd0;
		reg_bytecnt = 16'd0;
		reg_datai = 8'd0;
		reg_read = 1'b0;
		reg_write = 1'b0;
		reg_hypaddress = 6'd0;
		sck = 1'b0;
		mosi = 1'b1; // Idle lines high
		miso = 1'b1;
		pdid_cs = 1'b1;
		void'($urandom(SEED));
		fd = $fopen("test/io_trig_patterns.txt", "r");
		if (fd == 0)
			fail_run("Could not open test/io_trig_patterns.txt for reading");
		else begin
			while (!$feof(fd)) begin
				if ($fgets(line, fd) != 0) begin
					n = $sscanf(line, "%s %h %h", op_s, arg1, arg2);
					if (n == 3 && op_s.getc(0) != "#") begin // Skip comments
						case (op_s)
							"W": op = OP_WRITE;
							"R": op = OP_READ;
							"H": op = OP_HYPLEN;
							"S": op = OP_SPI;
							"U": op = OP_UART;
							"C": op = OP_WAIT;
							"T": op = OP_TRIG;
							default: fail_run({"Unknown operation ", op_s, " in pattern file"});
						endcase
						op_q.push_back(op);
						arg1_q.push_back(arg1);
						arg2_q.push_back(arg2);
					end
				end
			end
			$fclose(fd);
		end
		// Longest line is a UART byte plus its gap
		watchdog_cycles = op_q.size() * (10 * UART_DIV + 16) + STRETCH_LEN;
		repeat (2) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		for (int i = 0; i < op_q.size(); i++) begin
			case (op_q[i])
				OP_WRITE: bus_write(arg1_q[i][5:0], arg2_q[i]);
				OP_READ:  bus_read(arg1_q[i][5:0], arg2_q[i]);
				OP_HYPLEN: begin
					reg_hypaddress = arg1_q[i][5:0];
					@(negedge clk);
					check_value("reg_hyplen", arg2_q[i][15:0], reg_hyplen);
				end
				OP_SPI:   send_spi_byte(arg1_q[i][7:0], arg2_q[i][0]);
				OP_UART:  send_uart_byte(arg1_q[i][7:0], arg2_q[i][0]);
				OP_WAIT:  repeat (arg1_q[i]) @(negedge clk);
				OP_TRIG:  wait_trig(arg1_q[i][0], int'(arg2_q[i]));
				default: ;
			endcase
		end
		$display(">>> PASS");
		$finish;
	end

	// Watchdog
	initial begin
		wait (watchdog_cycles > 0);
		repeat (watchdog_cycles) @(posedge clk);
		fail_run($sformatf("Timeout after %0d cycles with the pattern run unfinished",
			watchdog_cycles));
	end

endmodule

// ==== vlog.f ====
+incdir+include
logic/io_trig_pkg.sv
logic/io_trig_regs.sv
logic/spi_byte_rx.sv
logic/uart_byte_rx.sv
logic/byte_pattern_match.sv
logic/io_decode_trig.sv
test/tb_io_decode_trig.sv
